//--- verilog.f
mchan_ctrl_pkg.sv
mchan_ctrl_fsm.sv
mchan_sid_tracker.sv
mchan_rsp_unit.sv
mchan_ctrl_top.sv
tb_mchan_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mchan_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat verilog.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verilog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f verilog.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mchan_ctrl.sv
`timescale 1ns/1ps

module tb_mchan_ctrl;
   import mchan_ctrl_pkg::*;

   localparam int NB_RUNS = 24;

   logic clk = 1'b0;
   logic rst_n;
   logic req, rd, gnt, r_valid;
   logic [31:0] add, wdata, r_data;
   logic [0:0] pe_id, r_id;
   logic cmd_gnt, cmd_req, cmd_inc, cmd_ele, cmd_ile, cmd_ble;
   mchan_opc_e cmd_opc;
   logic [LEN_WIDTH-1:0] cmd_len;
   logic [SID_WIDTH-1:0] cmd_sid, arb_sid, alloc_ret, alloc_sid;
   logic tcdm_gnt, tcdm_req, ext_gnt, ext_req;
   logic [TCDM_ADD_WIDTH-1:0] tcdm_add;
   logic [EXT_ADD_WIDTH-1:0] ext_add;
   logic arb_req, arb_gnt, alloc_req, alloc_gnt, busy;
   logic [NB_TRANSFERS-1:0] alloc_clr, alloc_status, trans_status, alloc_m, status_m;
   logic [31:0] exp_word; // Word currently presented to a FIFO
   logic arb_seen;
   logic acc_prev;        // Request accepted in the previous cycle
   int arb_cnt, st_cnt, cmd_cnt, tcdm_cnt, ext_cnt, checks, errors;

   always #20 clk = ~clk;

   mchan_ctrl_top dut_i (
      .clk_i(clk), .rst_ni(rst_n),
      .ctrl_targ_req_i(req), .ctrl_targ_type_i(rd), .ctrl_targ_add_i(add),
      .ctrl_targ_data_i(wdata), .ctrl_targ_id_i(pe_id), .ctrl_targ_gnt_o(gnt),
      .ctrl_targ_r_valid_o(r_valid), .ctrl_targ_r_data_o(r_data), .ctrl_targ_r_id_o(r_id),
      .cmd_gnt_i(cmd_gnt), .cmd_req_o(cmd_req), .cmd_len_o(cmd_len), .cmd_opc_o(cmd_opc),
      .cmd_inc_o(cmd_inc), .cmd_ele_o(cmd_ele), .cmd_ile_o(cmd_ile), .cmd_ble_o(cmd_ble),
      .cmd_sid_o(cmd_sid), .tcdm_gnt_i(tcdm_gnt), .tcdm_req_o(tcdm_req), .tcdm_add_o(tcdm_add),
      .ext_gnt_i(ext_gnt), .ext_req_o(ext_req), .ext_add_o(ext_add),
      .arb_req_i(arb_req), .arb_gnt_i(arb_gnt), .arb_sid_i(arb_sid),
      .trans_alloc_req_o(alloc_req), .trans_alloc_gnt_i(alloc_gnt),
      .trans_alloc_ret_i(alloc_ret), .trans_alloc_clr_o(alloc_clr),
      .trans_alloc_status_i(alloc_status), .trans_status_i(trans_status), .busy_o(busy)
   );

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic finish_run;
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      errors++;
      finish_run();
   endtask

   // First free sid from a random starting slot
   function automatic logic [SID_WIDTH-1:0] pick_free(input logic [NB_TRANSFERS-1:0] used);
      int start;
      logic [SID_WIDTH-1:0] s;
      start = $urandom_range(0, NB_TRANSFERS-1);
      pick_free = SID_WIDTH'(start);
      for (int i = NB_TRANSFERS-1; i >= 0; i--)
      begin
         s = SID_WIDTH'(start + i);
         if (!used[s])
            pick_free = s;
      end
   endfunction

   // ************************************************************
   // Environment responders driven on the rising edge
   // ************************************************************
   always @(posedge clk)
   begin
      cmd_gnt      <= ($urandom_range(0, 3) != 0);
      tcdm_gnt     <= ($urandom_range(0, 3) != 0);
      ext_gnt      <= ($urandom_range(0, 2) != 0);
      alloc_gnt    <= (alloc_m != '1) && ($urandom_range(0, 1) == 1);
      alloc_ret    <= pick_free(alloc_m);
      alloc_status <= alloc_m;
      trans_status <= status_m;
      arb_req      <= (arb_cnt == 1) || ($urandom_range(0, 3) == 0);
      arb_gnt      <= (arb_cnt == 1) || ($urandom_range(0, 3) == 0);
      arb_sid      <= (arb_cnt == 1) ? alloc_sid // Other sids win the arbiter at random
                                     : alloc_sid + SID_WIDTH'($urandom_range(1, NB_TRANSFERS-1));
   end

   // Allocator, arbiter and status model sampled at the falling edge
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         compare(r_valid, acc_prev, "valid one cycle after grant");
         acc_prev = req && gnt;
         if (alloc_req && alloc_gnt)
         begin
            alloc_sid          = alloc_ret;
            alloc_m[alloc_ret] = 1'b1;
         end
         alloc_m  = alloc_m & ~alloc_clr;
         status_m = status_m & ~alloc_clr;
         if (cmd_req && cmd_gnt)
         begin
            cmd_cnt++;
            compare(cmd_len, LEN_WIDTH'(exp_word[LEN_WIDTH-1:0] - 1), "cmd length");
            compare(cmd_opc, exp_word[OPC_BIT], "cmd opcode");
            compare({cmd_inc, cmd_ele, cmd_ile, cmd_ble},
                    {exp_word[INC_BIT], exp_word[ELE_BIT], exp_word[ILE_BIT], exp_word[BLE_BIT]},
                    "cmd flags");
            compare(cmd_sid, alloc_sid, "cmd sid");
            arb_cnt = $urandom_range(2, 12);
            st_cnt  = $urandom_range(2, 14);
         end
         if (tcdm_req && tcdm_gnt)
         begin
            tcdm_cnt++;
            compare(tcdm_add, exp_word[TCDM_ADD_WIDTH-1:0], "tcdm address");
         end
         if (ext_req && ext_gnt)
         begin
            ext_cnt++;
            compare(ext_add, exp_word[EXT_ADD_WIDTH-1:0], "ext address");
         end
         if (arb_cnt > 0)
            arb_cnt--;
         if (st_cnt > 0)
         begin
            st_cnt--;
            if (st_cnt == 0)
               status_m[alloc_sid] = 1'b1; // Transfer completes
         end
         if (arb_req && arb_gnt && arb_sid == alloc_sid)
            arb_seen = 1'b1;
      end
   end

   // One register access with its read data and ungranted cycles
   task automatic access(input logic is_rd, input logic [1:0] off, input logic [31:0] data,
                         output logic [31:0] rdata, output int waits);
      logic [0:0] id;
      id    = 1'($urandom);
      waits = 0;
      exp_word = data;
      @(posedge clk);
      req   <= 1'b1;
      rd    <= is_rd;
      add   <= {28'h0, off, 2'b00};
      wdata <= data;
      pe_id <= id;
      @(negedge clk);
      while (!gnt)
      begin
         waits++;
         if (waits > 200)
            abort_on_timeout("target grant");
         @(negedge clk);
      end
      if (!is_rd && off == STATUS_OFFSET)
         compare(alloc_clr, data[NB_TRANSFERS-1:0], "clear vector");
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      compare(r_valid, 1'b1, "response valid");
      compare(r_id, id, "response id");
      rdata = r_data;
   endtask

   task automatic wait_done;
      int n;
      n = 0;
      while (busy)
      begin
         n++;
         if (n > 300)
            abort_on_timeout("busy to fall");
         @(negedge clk);
      end
      compare({arb_seen, trans_status[alloc_sid]}, 2'b11, "busy fell early");
   endtask

   initial
   begin
      logic [31:0] rdata;
      int waits;
      void'($urandom(32'h2ce3));
      rst_n = 1'b0;
      {req, rd, add, wdata, pe_id} = '0;
      {cmd_gnt, tcdm_gnt, ext_gnt, alloc_gnt, arb_req, arb_gnt} = '0;
      {arb_sid, alloc_ret, alloc_status, trans_status} = '0;
      {alloc_m, status_m, alloc_sid, exp_word, arb_seen, acc_prev} = '0;
      {arb_cnt, st_cnt, cmd_cnt, tcdm_cnt, ext_cnt, checks, errors} = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      @(negedge clk);
      compare({busy, gnt, r_valid, cmd_req, tcdm_req, ext_req, alloc_req, alloc_clr}, '0,
              "outputs after reset");
      $display("Test reset: done");

      access(1'b1, STATUS_OFFSET, 32'h0, rdata, waits);
      compare(rdata, (32'(alloc_status) << ALLOC_STATUS_LSB) | 32'(trans_status), "status");
      $display("Test status read: done");

      for (int t = 0; t < NB_RUNS; t++)
      begin
         {cmd_cnt, tcdm_cnt, ext_cnt} = '0;
         arb_seen = 1'b0;
         access(1'b1, CMD_OFFSET, 32'h0, rdata, waits);
         compare(rdata, 32'(alloc_sid), "sid read");
         access(1'b0, CMD_OFFSET, $urandom, rdata, waits);
         compare(rdata, 32'h0, "cmd ack");
         access(1'b0, CMD_OFFSET, $urandom, rdata, waits);
         compare(rdata, 32'h0, "tcdm ack");
         access(1'b0, CMD_OFFSET, $urandom, rdata, waits);
         compare(rdata, 32'h0, "ext ack");
         wait_done();
         compare(cmd_cnt, 1, "cmd words accepted");
         compare(tcdm_cnt, 1, "tcdm words accepted");
         compare(ext_cnt, 1, "ext words accepted");
         access(1'b0, STATUS_OFFSET, 32'(1 << alloc_sid), rdata, waits);
         compare(rdata, 32'h0, "clear ack");
         access(1'b1, STATUS_OFFSET, 32'h0, rdata, waits);
         compare(waits, 0, "status grant after idle");
         compare(rdata, (32'(alloc_status) << ALLOC_STATUS_LSB) | 32'(trans_status), "status");
      end
      $display("Test random transfers: done");

      // Status read in place of the command word
      access(1'b1, CMD_OFFSET, 32'h0, rdata, waits);
      access(1'b1, STATUS_OFFSET, 32'h0, rdata, waits);
      compare(waits, 1, "aborted request grant delay");
      compare(rdata, (32'(alloc_status) << ALLOC_STATUS_LSB) | 32'(trans_status), "status");
      access(1'b0, STATUS_OFFSET, 32'(1 << alloc_sid), rdata, waits);
      $display("Test abort: done");

      finish_run();
   end

endmodule

//--- mchan_ctrl_top.sv
`timescale 1ns/1ps

module mchan_ctrl_top
(
   input  logic                                      clk_i,
   input  logic                                      rst_ni,

   // Register target port
   input  logic                                      ctrl_targ_req_i,
   input  logic                                      ctrl_targ_type_i,
   input  logic [31:0]                               ctrl_targ_add_i,
   input  logic [mchan_ctrl_pkg::DATA_WIDTH-1:0]     ctrl_targ_data_i,
   input  logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0]    ctrl_targ_id_i,
   output logic                                      ctrl_targ_gnt_o,
   output logic                                      ctrl_targ_r_valid_o,
   output logic [mchan_ctrl_pkg::DATA_WIDTH-1:0]     ctrl_targ_r_data_o,
   output logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0]    ctrl_targ_r_id_o,

   // Command FIFO
   input  logic                                      cmd_gnt_i,
   output logic                                      cmd_req_o,
   output logic [mchan_ctrl_pkg::LEN_WIDTH-1:0]      cmd_len_o,
   output mchan_ctrl_pkg::mchan_opc_e                cmd_opc_o,
   output logic                                      cmd_inc_o,
   output logic                                      cmd_ele_o,
   output logic                                      cmd_ile_o,
   output logic                                      cmd_ble_o,
   output logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      cmd_sid_o,

   // Address FIFOs
   input  logic                                      tcdm_gnt_i,
   output logic                                      tcdm_req_o,
   output logic [mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_add_o,
   input  logic                                      ext_gnt_i,
   output logic                                      ext_req_o,
   output logic [mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0]  ext_add_o,

   // Arbiter
   input  logic                                      arb_req_i,
   input  logic                                      arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      arb_sid_i,

   // Transfer allocator and status
   output logic                                      trans_alloc_req_o,
   input  logic                                      trans_alloc_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      trans_alloc_ret_i,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_alloc_clr_o,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_alloc_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_status_i,

   output logic                                      busy_o
);
   import mchan_ctrl_pkg::*;

   rsp_kind_e rsp_kind;
   logic      arb_pending;
   logic      sid_done;

   mchan_ctrl_fsm i_ctrl_fsm
   (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .ctrl_targ_req_i   (ctrl_targ_req_i),
      .ctrl_targ_type_i  (ctrl_targ_type_i),
      .ctrl_targ_add_i   (ctrl_targ_add_i),
      .ctrl_targ_data_i  (ctrl_targ_data_i),
      .ctrl_targ_gnt_o   (ctrl_targ_gnt_o),
      .rsp_kind_o        (rsp_kind),
      .cmd_gnt_i         (cmd_gnt_i),
      .cmd_req_o         (cmd_req_o),
      .cmd_len_o         (cmd_len_o),
      .cmd_opc_o         (cmd_opc_o),
      .cmd_inc_o         (cmd_inc_o),
      .cmd_ele_o         (cmd_ele_o),
      .cmd_ile_o         (cmd_ile_o),
      .cmd_ble_o         (cmd_ble_o),
      .tcdm_gnt_i        (tcdm_gnt_i),
      .tcdm_req_o        (tcdm_req_o),
      .tcdm_add_o        (tcdm_add_o),
      .ext_gnt_i         (ext_gnt_i),
      .ext_req_o         (ext_req_o),
      .ext_add_o         (ext_add_o),
      .trans_alloc_gnt_i (trans_alloc_gnt_i),
      .trans_alloc_req_o (trans_alloc_req_o),
      .trans_alloc_clr_o (trans_alloc_clr_o),
      .arb_pending_i     (arb_pending),
      .sid_done_i        (sid_done),
      .busy_o            (busy_o)
   );

   // Sid feeds the command FIFO and the sid read response
   mchan_sid_tracker i_sid_tracker
   (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .trans_alloc_req_i (trans_alloc_req_o),
      .trans_alloc_gnt_i (trans_alloc_gnt_i),
      .trans_alloc_ret_i (trans_alloc_ret_i),
      .cmd_req_i         (cmd_req_o),
      .cmd_gnt_i         (cmd_gnt_i),
      .arb_req_i         (arb_req_i),
      .arb_gnt_i         (arb_gnt_i),
      .arb_sid_i         (arb_sid_i),
      .trans_status_i    (trans_status_i),
      .sid_o             (cmd_sid_o),
      .arb_pending_o     (arb_pending),
      .sid_done_o        (sid_done)
   );

   mchan_rsp_unit i_rsp_unit
   (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .rsp_kind_i           (rsp_kind),
      .ctrl_targ_req_i      (ctrl_targ_req_i),
      .ctrl_targ_gnt_i      (ctrl_targ_gnt_o),
      .ctrl_targ_id_i       (ctrl_targ_id_i),
      .sid_i                (cmd_sid_o),
      .trans_status_i       (trans_status_i),
      .trans_alloc_status_i (trans_alloc_status_i),
      .ctrl_targ_r_valid_o  (ctrl_targ_r_valid_o),
      .ctrl_targ_r_data_o   (ctrl_targ_r_data_o),
      .ctrl_targ_r_id_o     (ctrl_targ_r_id_o)
   );

endmodule

//--- mchan_rsp_unit.sv
`timescale 1ns/1ps

module mchan_rsp_unit
(
   input  logic                                    clk_i,
   input  logic                                    rst_ni,

   input  mchan_ctrl_pkg::rsp_kind_e               rsp_kind_i,
   input  logic                                    ctrl_targ_req_i,
   input  logic                                    ctrl_targ_gnt_i,
   input  logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0]  ctrl_targ_id_i,

   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]    sid_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_alloc_status_i,

   output logic                                    ctrl_targ_r_valid_o,
   output logic [mchan_ctrl_pkg::DATA_WIDTH-1:0]   ctrl_targ_r_data_o,
   output logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0]  ctrl_targ_r_id_o
);
   import mchan_ctrl_pkg::*;

   rsp_kind_e              kind_q;
   logic [PE_ID_WIDTH-1:0] id_q;
   logic                   accept;

   assign accept = ctrl_targ_req_i && ctrl_targ_gnt_i;

   // One response slot per accepted request
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         kind_q <= RSP_NONE;
      else
         kind_q <= accept ? rsp_kind_i : RSP_NONE;
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
         id_q <= ctrl_targ_id_i; // Requester to route the response back
   end

   // **********************************************************
   // Read data
   // **********************************************************
   always_comb
   begin
      ctrl_targ_r_data_o = '0;
      case (kind_q)
         RSP_SID:
            ctrl_targ_r_data_o[SID_WIDTH-1:0] = sid_i; // Sid stored on the same edge
         RSP_STATUS:
         begin
            ctrl_targ_r_data_o[NB_TRANSFERS-1:0]                 = trans_status_i;
            ctrl_targ_r_data_o[ALLOC_STATUS_LSB +: NB_TRANSFERS] = trans_alloc_status_i;
         end
         default:
            ctrl_targ_r_data_o = '0; // Write acknowledge
      endcase
   end

   assign ctrl_targ_r_valid_o = (kind_q != RSP_NONE);
   assign ctrl_targ_r_id_o    = id_q;

   // Every grant from the FSM carries a response kind
   a_rsp_follows_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      accept |=> ctrl_targ_r_valid_o);

endmodule

//--- mchan_sid_tracker.sv
`timescale 1ns/1ps

module mchan_sid_tracker
(
   input  logic                                    clk_i,
   input  logic                                    rst_ni,

   input  logic                                    trans_alloc_req_i,
   input  logic                                    trans_alloc_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]    trans_alloc_ret_i,

   input  logic                                    cmd_req_i,
   input  logic                                    cmd_gnt_i,

   input  logic                                    arb_req_i,
   input  logic                                    arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]    arb_sid_i,

   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0] trans_status_i,

   output logic [mchan_ctrl_pkg::SID_WIDTH-1:0]    sid_o,
   output logic                                    arb_pending_o,
   output logic                                    sid_done_o
);
   import mchan_ctrl_pkg::*;

   logic [SID_WIDTH-1:0] sid_q;
   logic                 barrier_q;
   logic                 barrier_set;
   logic                 barrier_clr;

   assign barrier_set = cmd_req_i && cmd_gnt_i;                          // Command queued
   assign barrier_clr = arb_req_i && arb_gnt_i && (arb_sid_i == sid_q);  // Our sid arbitrated

   // Sid handed out by the allocator
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         sid_q <= '0;
      else if (trans_alloc_req_i && trans_alloc_gnt_i)
         sid_q <= trans_alloc_ret_i;
   end

   // Keeps the next transfer out until this command has been arbitrated
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         barrier_q <= 1'b0;
      else if (barrier_set)
         barrier_q <= 1'b1;
      else if (barrier_clr)
         barrier_q <= 1'b0;
   end

   assign sid_o         = sid_q;
   assign arb_pending_o = barrier_q;
   assign sid_done_o    = trans_status_i[sid_q];

   // The arbiter cannot see a command before the FIFO has taken it
   a_barrier_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(barrier_set && barrier_clr));

endmodule

//--- mchan_ctrl_fsm.sv
`timescale 1ns/1ps

module mchan_ctrl_fsm
(
   input  logic                                      clk_i,
   input  logic                                      rst_ni,

   input  logic                                      ctrl_targ_req_i,
   input  logic                                      ctrl_targ_type_i,
   input  logic [31:0]                               ctrl_targ_add_i,
   input  logic [mchan_ctrl_pkg::DATA_WIDTH-1:0]     ctrl_targ_data_i,
   output logic                                      ctrl_targ_gnt_o,
   output mchan_ctrl_pkg::rsp_kind_e                 rsp_kind_o,

   input  logic                                      cmd_gnt_i,
   output logic                                      cmd_req_o,
   output logic [mchan_ctrl_pkg::LEN_WIDTH-1:0]      cmd_len_o,
   output mchan_ctrl_pkg::mchan_opc_e                cmd_opc_o,
   output logic                                      cmd_inc_o,
   output logic                                      cmd_ele_o,
   output logic                                      cmd_ile_o,
   output logic                                      cmd_ble_o,

   input  logic                                      tcdm_gnt_i,
   output logic                                      tcdm_req_o,
   output logic [mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0] tcdm_add_o,

   input  logic                                      ext_gnt_i,
   output logic                                      ext_req_o,
   output logic [mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0]  ext_add_o,

   input  logic                                      trans_alloc_gnt_i,
   output logic                                      trans_alloc_req_o,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_alloc_clr_o,

   input  logic                                      arb_pending_i,
   input  logic                                      sid_done_i,
   output logic                                      busy_o
);
   import mchan_ctrl_pkg::*;

   ctrl_state_e state_q, state_d;
   logic [1:0]  offset;
   logic        seq_write;   // Expected word of the programming sequence
   logic        abort;       // Anything else presented mid-sequence

   assign offset    = ctrl_targ_add_i[3:2];
   assign seq_write = ctrl_targ_req_i && !ctrl_targ_type_i && (offset == CMD_OFFSET);
   assign abort     = ctrl_targ_req_i && !seq_write;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // **********************************************************
   // Sequence decode
   // **********************************************************
   always_comb
   begin
      state_d           = state_q;
      ctrl_targ_gnt_o   = 1'b0;
      rsp_kind_o        = RSP_NONE;
      trans_alloc_req_o = 1'b0;
      trans_alloc_clr_o = '0;
      cmd_req_o         = 1'b0;
      tcdm_req_o        = 1'b0;
      ext_req_o         = 1'b0;
      busy_o            = 1'b1;

      case (state_q)
         IDLE:
         begin
            busy_o = ctrl_targ_req_i;
            if (ctrl_targ_req_i && offset == CMD_OFFSET && ctrl_targ_type_i)
            begin
               if (trans_alloc_gnt_i) // Free sid available
               begin
                  ctrl_targ_gnt_o   = 1'b1;
                  trans_alloc_req_o = 1'b1;
                  rsp_kind_o        = RSP_SID;
                  state_d           = SID_RSP;
               end
            end
            else if (ctrl_targ_req_i && offset == STATUS_OFFSET)
            begin
               ctrl_targ_gnt_o = 1'b1;
               if (ctrl_targ_type_i)
               begin
                  rsp_kind_o = RSP_STATUS;
                  state_d    = STATUS_RSP;
               end
               else
               begin
                  trans_alloc_clr_o = ctrl_targ_data_i[NB_TRANSFERS-1:0];
                  rsp_kind_o        = RSP_ACK;
                  state_d           = CLEAR_RSP;
               end
            end
         end

         STATUS_RSP, CLEAR_RSP:
            state_d = IDLE;

         SID_RSP, CMD_WAIT:
         begin
            if (abort)
               state_d = IDLE;
            else if (seq_write && cmd_gnt_i)
            begin
               ctrl_targ_gnt_o = 1'b1;
               cmd_req_o       = 1'b1;
               rsp_kind_o      = RSP_ACK;
               state_d         = CMD_RSP;
            end
            else
               state_d = CMD_WAIT;
         end

         CMD_RSP, TCDM_WAIT:
         begin
            if (abort)
               state_d = IDLE;
            else if (seq_write && tcdm_gnt_i)
            begin
               ctrl_targ_gnt_o = 1'b1;
               tcdm_req_o      = 1'b1;
               rsp_kind_o      = RSP_ACK;
               state_d         = TCDM_RSP;
            end
            else
               state_d = TCDM_WAIT;
         end

         TCDM_RSP, EXT_WAIT:
         begin
            if (abort)
               state_d = IDLE;
            else if (seq_write && ext_gnt_i)
            begin
               ctrl_targ_gnt_o = 1'b1;
               ext_req_o       = 1'b1;
               rsp_kind_o      = RSP_ACK;
               state_d         = EXT_RSP;
            end
            else
               state_d = EXT_WAIT;
         end

         EXT_RSP:
            state_d = WAIT_ARB;

         WAIT_ARB:
         begin
            if (!arb_pending_i) // Command picked up by the arbiter
               state_d = WAIT_DONE;
         end

         WAIT_DONE:
         begin
            if (sid_done_i)
               state_d = IDLE;
         end

         default:
            state_d = IDLE;
      endcase
   end

   // Command word slicing without the 2D flags at bits 19 and 23
   assign cmd_len_o  = ctrl_targ_data_i[LEN_WIDTH-1:0] - 1'b1;
   assign cmd_opc_o  = mchan_opc_e'(ctrl_targ_data_i[OPC_BIT]);
   assign cmd_inc_o  = ctrl_targ_data_i[INC_BIT];
   assign cmd_ele_o  = ctrl_targ_data_i[ELE_BIT]; // Event lines
   assign cmd_ile_o  = ctrl_targ_data_i[ILE_BIT]; // Interrupt lines
   assign cmd_ble_o  = ctrl_targ_data_i[BLE_BIT]; // Broadcast lines
   assign tcdm_add_o = ctrl_targ_data_i[TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = ctrl_targ_data_i[EXT_ADD_WIDTH-1:0];

   // Queues only see a word that the PE also sees accepted
   a_req_with_gnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cmd_req_o || tcdm_req_o || ext_req_o || trans_alloc_req_o) |-> ctrl_targ_gnt_o);

   a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_q inside {[IDLE:WAIT_DONE]});

endmodule

//--- mchan_ctrl_pkg.sv
package mchan_ctrl_pkg;

   // **********************************************************
   // Sizes
   // **********************************************************
   localparam int NB_TRANSFERS   = 4;
   localparam int SID_WIDTH      = $clog2(NB_TRANSFERS);
   localparam int TCDM_ADD_WIDTH = 12;
   localparam int EXT_ADD_WIDTH  = 29;
   localparam int LEN_WIDTH      = 17;
   localparam int PE_ID_WIDTH    = 1;
   localparam int DATA_WIDTH     = 32;

   // **********************************************************
   // Register map and command word layout
   // **********************************************************
   localparam logic [1:0] CMD_OFFSET    = 2'd0; // Compared against add[3:2]
   localparam logic [1:0] STATUS_OFFSET = 2'd1;

   localparam int OPC_BIT = 17; // Length sits in bits 16:0
   localparam int INC_BIT = 18;
   localparam int ELE_BIT = 20; // Bit 19 was the ext side 2D flag
   localparam int ILE_BIT = 21;
   localparam int BLE_BIT = 22;

   localparam int ALLOC_STATUS_LSB = 16; // Allocation vector in status read

   typedef enum logic [3:0] {
      IDLE,
      SID_RSP,
      STATUS_RSP,
      CLEAR_RSP,
      CMD_WAIT,
      CMD_RSP,
      TCDM_WAIT,
      TCDM_RSP,
      EXT_WAIT,
      EXT_RSP,
      WAIT_ARB,
      WAIT_DONE
   } ctrl_state_e;

   typedef enum logic [1:0] {
      RSP_NONE,
      RSP_ACK,
      RSP_SID,
      RSP_STATUS
   } rsp_kind_e;

   // TX moves data from TCDM to external memory
   typedef enum logic {
      OPC_TX = 1'b0,
      OPC_RX = 1'b1
   } mchan_opc_e;

endpackage
